//--- sparcPkg.sv
package sparcPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [3:0]  cond_t;
    typedef logic [12:0] simm13_t;
    typedef logic [21:0] imm22_t;   // disp22 and SETHI imm22 share this field

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } ccFlags_t;

    typedef struct packed {
        logic     en;
        regAddr_t rd;
        word_t    data;
    } regWrite_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetchReg_t;

    typedef struct packed {
        logic   regWrite;
        aluOp_t aluOp;
        logic   useImm;
        logic   isSethi;
        logic   modifyCc;
        logic   isBranch;
        cond_t  cond;
    } ctrl_t;

    // Major opcodes in bits 31:30
    localparam logic [1:0] OpBranchSethi = 2'b00;
    localparam logic [1:0] OpArith       = 2'b10;

    localparam logic [2:0] Op2Bicc  = 3'b010;   // op2 in bits 24:22
    localparam logic [2:0] Op2Sethi = 3'b100;

    localparam logic [5:0] Op3Sll = 6'b100101;
    localparam logic [5:0] Op3Srl = 6'b100110;
    localparam logic [5:0] Op3Sra = 6'b100111;

    localparam int OpHi      = 31;
    localparam int OpLo      = 30;
    localparam int RdHi      = 29;
    localparam int RdLo      = 25;
    localparam int AnnulBit  = 29;
    localparam int CondHi    = 28;
    localparam int CondLo    = 25;
    localparam int Op2Hi     = 24;
    localparam int Op2Lo     = 22;
    localparam int Op3Hi     = 24;
    localparam int Op3Lo     = 19;
    localparam int Rs1Hi     = 18;
    localparam int Rs1Lo     = 14;
    localparam int IBit      = 13;
    localparam int Simm13Hi  = 12;
    localparam int Simm13Lo  = 0;
    localparam int Rs2Hi     = 4;
    localparam int Rs2Lo     = 0;
    localparam int Disp22Hi  = 21;
    localparam int Disp22Lo  = 0;

    localparam aluOp_t AluAdd   = 4'd0;
    localparam aluOp_t AluSub   = 4'd1;
    localparam aluOp_t AluAnd   = 4'd2;
    localparam aluOp_t AluOr    = 4'd3;
    localparam aluOp_t AluXor   = 4'd4;
    localparam aluOp_t AluAndn  = 4'd5;
    localparam aluOp_t AluOrn   = 4'd6;
    localparam aluOp_t AluXnor  = 4'd7;
    localparam aluOp_t AluSll   = 4'd8;
    localparam aluOp_t AluSrl   = 4'd9;
    localparam aluOp_t AluSra   = 4'd10;
    localparam aluOp_t AluPassB = 4'd11;

    localparam word_t InstrBytes = 32'd4;
    localparam word_t ResetPc    = 32'd0;

    localparam cond_t CondNever  = 4'b0000;
    localparam cond_t CondAlways = 4'b1000;

endpackage

//--- fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit
(
    input  logic                Clk,
    input  logic                rstN,
    input  logic                branchTaken,
    input  logic                annulSlot,
    input  sparcPkg::word_t     branchTarget,
    input  sparcPkg::word_t     instr,
    output sparcPkg::word_t     fetchAddr,
    output sparcPkg::fetchReg_t ifId
);
    import sparcPkg::*;

    word_t pc;
    word_t nextPc;

    // Branch in decode steers the fetch after its delay slot
    assign nextPc    = branchTaken ? branchTarget : pc + InstrBytes;
    assign fetchAddr = pc;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc   <= ResetPc;
            ifId <= '0;
        end
        else
        begin
            pc         <= nextPc;
            ifId.valid <= !annulSlot;   // Squashed slot enters decode as a bubble
            ifId.pc    <= pc;
            ifId.instr <= instr;
        end
    end

endmodule

//--- instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder
(
    input  sparcPkg::fetchReg_t ifId,
    output sparcPkg::ctrl_t     ctrl
);
    import sparcPkg::*;

    logic [1:0] op;
    logic [2:0] op2;
    logic [5:0] op3;
    regAddr_t   rd;
    logic       legal;   // Kept instruction that produces a register result

    assign op  = ifId.instr[OpHi:OpLo];
    assign op2 = ifId.instr[Op2Hi:Op2Lo];
    assign op3 = ifId.instr[Op3Hi:Op3Lo];
    assign rd  = ifId.instr[RdHi:RdLo];

    always_comb
    begin
        ctrl      = '0;
        ctrl.cond = CondNever;
        legal     = 1'b0;
        case (op)
            OpBranchSethi:
            begin
                if (op2 == Op2Sethi)
                begin
                    legal        = 1'b1;
                    ctrl.isSethi = 1'b1;
                    ctrl.aluOp   = AluPassB;
                end
                else if (op2 == Op2Bicc)
                begin
                    ctrl.isBranch = 1'b1;
                    ctrl.cond     = ifId.instr[CondHi:CondLo];
                end
            end
            OpArith:
            begin
                ctrl.useImm = ifId.instr[IBit];
                // Logic and add/sub group; bit 3 set would be the carry forms
                if (!op3[5] && !op3[3])
                begin
                    legal         = 1'b1;
                    ctrl.modifyCc = op3[4];   // op3 bit 4 is instruction bit 23
                    case (op3[2:0])
                        3'b000:  ctrl.aluOp = AluAdd;
                        3'b001:  ctrl.aluOp = AluAnd;
                        3'b010:  ctrl.aluOp = AluOr;
                        3'b011:  ctrl.aluOp = AluXor;
                        3'b100:  ctrl.aluOp = AluSub;
                        3'b101:  ctrl.aluOp = AluAndn;
                        3'b110:  ctrl.aluOp = AluOrn;
                        default: ctrl.aluOp = AluXnor;
                    endcase
                end
                else
                begin
                    legal = 1'b1;
                    case (op3)
                        Op3Sll:  ctrl.aluOp = AluSll;
                        Op3Srl:  ctrl.aluOp = AluSrl;
                        Op3Sra:  ctrl.aluOp = AluSra;
                        default: legal = 1'b0;   // Not supported, acts as nop
                    endcase
                end
            end
            default: legal = 1'b0;
        endcase

        ctrl.regWrite = legal && ifId.valid && (rd != '0);
        if (!ifId.valid)
        begin
            ctrl.isBranch = 1'b0;
            ctrl.modifyCc = 1'b0;   // Bubble must not touch the PSR
        end
    end

endmodule

//--- branchCondition.sv
`timescale 1ns/100ps

module branchCondition
(
    input  sparcPkg::ctrl_t    ctrl,
    input  sparcPkg::word_t    pc,
    input  sparcPkg::imm22_t   disp22,
    input  logic               annulBit,
    input  sparcPkg::ccFlags_t ccNow,
    output logic               branchTaken,
    output logic               annulSlot,
    output sparcPkg::word_t    branchTarget
);
    import sparcPkg::*;

    logic  baseTrue;
    logic  condTrue;
    word_t dispExt;

    // Lower three cond bits pick the test, cond[3] inverts it
    always_comb
    begin
        case (ctrl.cond[2:0])
            3'b000:  baseTrue = 1'b0;                          // bn / ba
            3'b001:  baseTrue = ccNow.z;                       // be / bne
            3'b010:  baseTrue = ccNow.z | (ccNow.n ^ ccNow.v); // ble / bg
            3'b011:  baseTrue = ccNow.n ^ ccNow.v;             // bl / bge
            3'b100:  baseTrue = ccNow.c | ccNow.z;             // bleu / bgu
            3'b101:  baseTrue = ccNow.c;                       // bcs / bcc
            3'b110:  baseTrue = ccNow.n;                       // bneg / bpos
            default: baseTrue = ccNow.v;                       // bvs / bvc
        endcase
    end

    assign condTrue    = baseTrue ^ ctrl.cond[3];
    assign branchTaken = ctrl.isBranch && condTrue;

    // ba,a skips its slot as well as any untaken annulled branch
    assign annulSlot = ctrl.isBranch && annulBit
                       && (!condTrue || ctrl.cond == CondAlways);

    assign dispExt      = {{10{disp22[21]}}, disp22};
    assign branchTarget = pc + dispExt * InstrBytes;   // Word displacement

endmodule

//--- regFile.sv
`timescale 1ns/100ps

module regFile
(
    input  logic                Clk,
    input  logic                rstN,
    input  sparcPkg::regAddr_t  rs1,
    input  sparcPkg::regAddr_t  rs2,
    input  sparcPkg::regWrite_t wr,
    output sparcPkg::word_t     rdDataA,
    output sparcPkg::word_t     rdDataB
);
    import sparcPkg::*;

    word_t regs [1:31];   // r0 has no storage

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr.en && wr.rd != '0)
            regs[wr.rd] <= wr.data;
    end

    // Same-cycle writes are covered by forwarding from writeback
    assign rdDataA = (rs1 == '0) ? '0 : regs[rs1];
    assign rdDataB = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- forwardUnit.sv
`timescale 1ns/100ps

module forwardUnit
(
    input  sparcPkg::regAddr_t  rs1,
    input  sparcPkg::regAddr_t  rs2,
    input  sparcPkg::word_t     rdDataA,
    input  sparcPkg::word_t     rdDataB,
    input  sparcPkg::regWrite_t exResult,
    input  sparcPkg::regWrite_t wbResult,
    output sparcPkg::word_t     operandA,
    output sparcPkg::word_t     operandB
);
    import sparcPkg::*;

    // Youngest producer wins
    function automatic word_t resolve(regAddr_t src, word_t rfData,
                                      regWrite_t ex, regWrite_t wb);
        if (ex.en && ex.rd == src)
            return ex.data;
        else if (wb.en && wb.rd == src)
            return wb.data;
        else
            return rfData;
    endfunction

    // Enables are never set for rd 0, so r0 always comes from the file
    assign operandA = resolve(rs1, rdDataA, exResult, wbResult);
    assign operandB = resolve(rs2, rdDataB, exResult, wbResult);

endmodule

//--- executeStage.sv
`timescale 1ns/100ps

module executeStage
(
    input  logic                Clk,
    input  logic                rstN,
    input  sparcPkg::ctrl_t     ctrl,
    input  sparcPkg::word_t     operandA,
    input  sparcPkg::word_t     operandB,
    input  sparcPkg::simm13_t   simm13,
    input  sparcPkg::imm22_t    imm22,
    input  sparcPkg::regAddr_t  rd,
    output sparcPkg::regWrite_t exResult,
    output sparcPkg::regWrite_t wbResult,
    output sparcPkg::ccFlags_t  ccNow
);
    import sparcPkg::*;

    ctrl_t    exCtrl;
    word_t    exA;
    word_t    exB;
    simm13_t  exSimm13;
    imm22_t   exImm22;
    regAddr_t exRd;

    word_t    operand2;
    word_t    aluResult;
    logic     aluCarry;
    logic     aluOver;
    ccFlags_t aluFlags;
    ccFlags_t psr;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            exCtrl <= '0;
        else
            exCtrl <= ctrl;
    end

    always_ff @(posedge Clk)
    begin
        exA      <= operandA;
        exB      <= operandB;
        exSimm13 <= simm13;
        exImm22  <= imm22;
        exRd     <= rd;
    end

    always_comb
    begin
        if (exCtrl.isSethi)
            operand2 = {exImm22, 10'b0};
        else if (exCtrl.useImm)
            operand2 = {{19{exSimm13[12]}}, exSimm13};
        else
            operand2 = exB;
    end

    always_comb
    begin
        aluCarry = 1'b0;
        aluOver  = 1'b0;
        case (exCtrl.aluOp)
            AluAdd:
            begin
                {aluCarry, aluResult} = {1'b0, exA} + {1'b0, operand2};
                aluOver = (exA[31] == operand2[31]) && (aluResult[31] != exA[31]);
            end
            AluSub:
            begin
                {aluCarry, aluResult} = {1'b0, exA} - {1'b0, operand2};   // C is the borrow
                aluOver = (exA[31] != operand2[31]) && (aluResult[31] != exA[31]);
            end
            AluAnd:  aluResult = exA & operand2;
            AluOr:   aluResult = exA | operand2;
            AluXor:  aluResult = exA ^ operand2;
            AluAndn: aluResult = exA & ~operand2;
            AluOrn:  aluResult = exA | ~operand2;
            AluXnor: aluResult = ~(exA ^ operand2);
            AluSll:  aluResult = exA << operand2[4:0];
            AluSrl:  aluResult = exA >> operand2[4:0];
            AluSra:  aluResult = $signed(exA) >>> operand2[4:0];
            default: aluResult = operand2;   // SETHI
        endcase
    end

    assign aluFlags.n = aluResult[31];
    assign aluFlags.z = (aluResult == '0);
    assign aluFlags.v = aluOver;
    assign aluFlags.c = aluCarry;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            psr <= '0;
        else if (exCtrl.modifyCc)
            psr <= aluFlags;
    end

    // Branch in decode sees the flags of a cc op still in execute
    assign ccNow = exCtrl.modifyCc ? aluFlags : psr;

    assign exResult.en   = exCtrl.regWrite;
    assign exResult.rd   = exRd;
    assign exResult.data = aluResult;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            wbResult <= '0;
        else
            wbResult <= exResult;
    end

endmodule

//--- sparcCore.sv
`timescale 1ns/100ps

module sparcCore
(
    input  logic                Clk,
    input  logic                rstN,
    input  sparcPkg::word_t     instr,
    output sparcPkg::word_t     fetchAddr,
    output sparcPkg::regWrite_t retire
);
    import sparcPkg::*;

    fetchReg_t ifId;
    ctrl_t     ctrl;
    logic      branchTaken;
    logic      annulSlot;
    word_t     branchTarget;
    ccFlags_t  ccNow;
    regAddr_t  rs1;
    regAddr_t  rs2;
    word_t     rdDataA;
    word_t     rdDataB;
    word_t     operandA;
    word_t     operandB;
    regWrite_t exResult;
    regWrite_t wbResult;

    assign rs1 = ifId.instr[Rs1Hi:Rs1Lo];
    assign rs2 = ifId.instr[Rs2Hi:Rs2Lo];

    fetchUnit fetch (
        .Clk          (Clk),
        .rstN         (rstN),
        .branchTaken  (branchTaken),
        .annulSlot    (annulSlot),
        .branchTarget (branchTarget),
        .instr        (instr),
        .fetchAddr    (fetchAddr),
        .ifId         (ifId)
    );

    instrDecoder decoder (
        .ifId (ifId),
        .ctrl (ctrl)
    );

    branchCondition branch (
        .ctrl         (ctrl),
        .pc           (ifId.pc),
        .disp22       (ifId.instr[Disp22Hi:Disp22Lo]),
        .annulBit     (ifId.instr[AnnulBit]),
        .ccNow        (ccNow),
        .branchTaken  (branchTaken),
        .annulSlot    (annulSlot),
        .branchTarget (branchTarget)
    );

    regFile regs (
        .Clk     (Clk),
        .rstN    (rstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .wr      (wbResult),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    forwardUnit forward (
        .rs1      (rs1),
        .rs2      (rs2),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .exResult (exResult),
        .wbResult (wbResult),
        .operandA (operandA),
        .operandB (operandB)
    );

    executeStage execute (
        .Clk      (Clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .operandA (operandA),
        .operandB (operandB),
        .simm13   (ifId.instr[Simm13Hi:Simm13Lo]),
        .imm22    (ifId.instr[Disp22Hi:Disp22Lo]),   // SETHI imm22 sits in the disp22 bits
        .rd       (ifId.instr[RdHi:RdLo]),
        .exResult (exResult),
        .wbResult (wbResult),
        .ccNow    (ccNow)
    );

    assign retire = wbResult;

endmodule

//--- sparcCore_assertions.sv
`timescale 1ns/100ps

module sparcCore_assertions
(
    input logic                Clk,
    input logic                rstN,
    input sparcPkg::word_t     instr,
    input sparcPkg::word_t     fetchAddr,
    input sparcPkg::regWrite_t retire
);
    import sparcPkg::*;

    int assertFails = 0;

    function automatic logic isBicc(word_t w);
        return w[OpHi:OpLo] == OpBranchSethi && w[Op2Hi:Op2Lo] == Op2Bicc;
    endfunction

    // Byte offset of a branch, word displacement times four
    function automatic word_t byteOffset(word_t w);
        return {{8{w[21]}}, w[21:0], 2'b00};
    endfunction

    // Nothing can reach writeback in the first three cycles after release
    noEarlyRetire: assert property (@(posedge Clk)
        (!rstN || !$past(rstN, 1) || !$past(rstN, 2) || !$past(rstN, 3)) |-> !retire.en)
    else
    begin
        $error("retire.en set during reset or too soon after it");
        assertFails++;
    end

    resetFetch: assert property (@(posedge Clk) !rstN |-> fetchAddr == ResetPc)
    else
    begin
        $error("fetchAddr not at the reset address during reset");
        assertFails++;
    end

    sequentialFetch: assert property (@(posedge Clk) disable iff (!rstN)
        ($past(rstN, 1) && $past(rstN, 2) && !isBicc($past(instr, 2)))
        |-> fetchAddr == $past(fetchAddr) + 32'd4)
    else
    begin
        $error("fetchAddr did not step by 4 without a branch in decode");
        assertFails++;
    end

    branchFetch: assert property (@(posedge Clk) disable iff (!rstN)
        ($past(rstN, 1) && $past(rstN, 2) && isBicc($past(instr, 2)))
        |-> fetchAddr == $past(fetchAddr) + 32'd4
            || fetchAddr == $past(fetchAddr, 2) + byteOffset($past(instr, 2)))
    else
    begin
        $error("fetchAddr after a branch is neither fall-through nor target");
        assertFails++;
    end

    noR0Retire: assert property (@(posedge Clk) retire.en |-> retire.rd != '0)
    else
    begin
        $error("retire reported a write to r0");
        assertFails++;
    end

    // Three cycles from fetch to retire, same rd field
    retireLatency: assert property (@(posedge Clk) disable iff (!rstN)
        retire.en |-> $past(instr[RdHi:RdLo], 3) == retire.rd && !$past(instr[OpLo], 3))
    else
    begin
        $error("retire does not match the instruction fetched three cycles earlier");
        assertFails++;
    end

endmodule

bind sparcCore sparcCore_assertions chk (
    .Clk       (Clk),
    .rstN      (rstN),
    .instr     (instr),
    .fetchAddr (fetchAddr),
    .retire    (retire)
);

//--- sparcCoreTb.sv
`timescale 1ns/100ps

module sparcCoreTb;
    import sparcPkg::*;

    localparam int MemBytes    = 1024;
    localparam int RetireLimit = 200;   // Cycles a program gets to retire
    localparam int DrainCycles = 6;     // Two pipeline depths past the last retire

    localparam logic [5:0] AddCode   = 6'h00;
    localparam logic [5:0] AndCode   = 6'h01;
    localparam logic [5:0] OrCode    = 6'h02;
    localparam logic [5:0] XorCode   = 6'h03;
    localparam logic [5:0] SubCode   = 6'h04;
    localparam logic [5:0] AndnCode  = 6'h05;
    localparam logic [5:0] OrnCode   = 6'h06;
    localparam logic [5:0] XnorCode  = 6'h07;
    localparam logic [5:0] AddccCode = 6'h10;
    localparam logic [5:0] SubccCode = 6'h14;
    localparam logic [5:0] SllCode   = 6'h25;
    localparam logic [5:0] SrlCode   = 6'h26;
    localparam logic [5:0] SraCode   = 6'h27;

    localparam cond_t BrAlways  = 4'b1000;
    localparam cond_t BrEq      = 4'b0001;
    localparam cond_t BrNe      = 4'b1001;
    localparam cond_t BrLess    = 4'b0011;
    localparam cond_t BrGreater = 4'b1010;

    logic      Clk;
    logic      rstN;
    word_t     instr;
    word_t     fetchAddr;
    regWrite_t retire;

    logic [7:0] imem [0:MemBytes-1];
    logic [9:0] memAddr;
    word_t      loadAddr;     // Next free program address
    regWrite_t  seen [$];
    regWrite_t  expected [$];
    int         errors;
    int         testCount;
    int         testFails;

    sparcCore uut (
        .Clk       (Clk),
        .rstN      (rstN),
        .instr     (instr),
        .fetchAddr (fetchAddr),
        .retire    (retire)
    );

    always #2 Clk = ~Clk;

    // Big-endian combinational fetch port
    assign memAddr = fetchAddr[9:0];
    assign instr   = {imem[memAddr], imem[memAddr + 10'd1],
                      imem[memAddr + 10'd2], imem[memAddr + 10'd3]};

    always @(posedge Clk)
    begin
        if (rstN && retire.en)
            seen.push_back(retire);
    end

    function automatic word_t regForm(logic [5:0] op3, regAddr_t rd, regAddr_t rs1,
                                      regAddr_t rs2);
        return {2'b10, rd, op3, rs1, 1'b0, 8'b0, rs2};
    endfunction

    function automatic word_t immForm(logic [5:0] op3, regAddr_t rd, regAddr_t rs1,
                                      simm13_t simm);
        return {2'b10, rd, op3, rs1, 1'b1, simm};
    endfunction

    function automatic word_t sethiWord(regAddr_t rd, imm22_t imm);
        return {2'b00, rd, 3'b100, imm};
    endfunction

    function automatic word_t branchWord(logic annul, cond_t cond, imm22_t disp);
        return {2'b00, annul, cond, 3'b010, disp};
    endfunction

    task automatic storeWord(input word_t addr, input word_t word);
        {imem[addr[9:0]], imem[addr[9:0] + 10'd1],
         imem[addr[9:0] + 10'd2], imem[addr[9:0] + 10'd3]} = word;
    endtask

    task automatic place(input word_t word);
        storeWord(loadAddr, word);
        loadAddr = loadAddr + 32'd4;
    endtask

    task automatic issue(input word_t word, input regAddr_t rd, input word_t data);
        place(word);
        expected.push_back({1'b1, rd, data});
    endtask

    // Marker that must never retire
    task automatic unreachable();
        place(immForm(OrCode, 5'd20, 5'd0, 13'hBAD));
    endtask

    task automatic startProgram();
        rstN = 1'b0;
        for (int a = 0; a < MemBytes; a += 4)
            storeWord(word_t'(a), word_t'(a));   // UNIMP with its address, decodes as nop
        loadAddr = ResetPc;
        expected.delete();
    endtask

    task automatic runTest(input string name);
        int cycles;
        int errorsBefore;
        int assertsBefore;
        errorsBefore  = errors;
        assertsBefore = uut.chk.assertFails;
        repeat (10) @(posedge Clk);
        #1;
        seen.delete();
        rstN   = 1'b1;
        cycles = 0;
        while (seen.size() < expected.size() && cycles < RetireLimit)
        begin
            @(posedge Clk);
            #1;
            cycles++;
        end
        if (seen.size() < expected.size())
        begin
            $display("%s: timed out after %0d cycles waiting for retires", name, cycles);
            errors++;
        end
        repeat (DrainCycles)
        begin
            @(posedge Clk);
            #1;
        end
        assert (seen.size() == expected.size())
        else
        begin
            $display("[FAIL] %s retire count: expected %h, got %h", name,
                     expected.size(), seen.size());
            errors++;
        end
        for (int i = 0; i < expected.size() && i < seen.size(); i++)
        begin
            assert (seen[i].rd == expected[i].rd)
            else
            begin
                $display("[FAIL] %s retire.rd #%0d: expected %h, got %h", name, i,
                         expected[i].rd, seen[i].rd);
                errors++;
            end
            assert (seen[i].data == expected[i].data)
            else
            begin
                $display("[FAIL] %s retire.data #%0d: expected %h, got %h", name, i,
                         expected[i].data, seen[i].data);
                errors++;
            end
        end
        testCount++;
        if (errors != errorsBefore || uut.chk.assertFails != assertsBefore)
        begin
            testFails++;
            $display("%s: mismatches found", name);
        end
        else
            $display("%s: ok, %0d retires", name, seen.size());
    endtask

    initial
    begin
        Clk       = 1'b0;
        rstN      = 1'b0;
        errors    = 0;
        testCount = 0;
        testFails = 0;

        startProgram();   // Empty program, only the reset and fetch checks act
        runTest("reset");

        startProgram();
        issue(immForm(OrCode, 5'd1, 5'd0, 13'h123), 5'd1, 32'h0000_0123);
        issue(sethiWord(5'd2, 22'h12345), 5'd2, 32'h048D_1400);
        issue(immForm(AddCode, 5'd3, 5'd0, 13'h1FFB), 5'd3, 32'hFFFF_FFFB);
        issue(immForm(OrCode, 5'd4, 5'd0, 13'h0F0), 5'd4, 32'h0000_00F0);
        issue(regForm(AddCode, 5'd5, 5'd1, 5'd2), 5'd5, 32'h048D_1523);
        issue(regForm(SubCode, 5'd6, 5'd1, 5'd4), 5'd6, 32'h0000_0033);
        issue(immForm(AndCode, 5'd7, 5'd1, 13'h0F0), 5'd7, 32'h0000_0020);
        issue(regForm(XorCode, 5'd8, 5'd1, 5'd4), 5'd8, 32'h0000_01D3);
        issue(regForm(AndnCode, 5'd9, 5'd1, 5'd4), 5'd9, 32'h0000_0103);
        issue(regForm(OrnCode, 5'd10, 5'd0, 5'd4), 5'd10, 32'hFFFF_FF0F);
        issue(regForm(XnorCode, 5'd11, 5'd1, 5'd4), 5'd11, 32'hFFFF_FE2C);
        issue(immForm(SllCode, 5'd12, 5'd1, 13'd4), 5'd12, 32'h0000_1230);
        issue(immForm(SrlCode, 5'd13, 5'd3, 13'd4), 5'd13, 32'h0FFF_FFFF);
        issue(immForm(SraCode, 5'd14, 5'd3, 13'd1), 5'd14, 32'hFFFF_FFFD);
        runTest("alu and sethi");

        startProgram();
        issue(immForm(OrCode, 5'd1, 5'd0, 13'd5), 5'd1, 32'd5);
        issue(immForm(AddCode, 5'd2, 5'd1, 13'd3), 5'd2, 32'd8);       // From execute
        issue(regForm(AddCode, 5'd3, 5'd1, 5'd2), 5'd3, 32'd13);       // Writeback and execute
        issue(regForm(SubCode, 5'd4, 5'd3, 5'd1), 5'd4, 32'd8);
        issue(regForm(SllCode, 5'd5, 5'd4, 5'd2), 5'd5, 32'h800);
        issue(immForm(OrCode, 5'd1, 5'd0, 13'h7FF), 5'd1, 32'h7FF);    // Stale r1 in the file
        issue(regForm(AddCode, 5'd6, 5'd1, 5'd1), 5'd6, 32'hFFE);
        issue(regForm(XorCode, 5'd7, 5'd1, 5'd6), 5'd7, 32'h801);
        issue(immForm(OrCode, 5'd8, 5'd0, 13'd1), 5'd8, 32'd1);
        issue(immForm(OrCode, 5'd8, 5'd0, 13'd2), 5'd8, 32'd2);
        issue(immForm(AddCode, 5'd9, 5'd8, 13'd0), 5'd9, 32'd2);       // Youngest r8 wins
        runTest("forwarding");

        startProgram();
        issue(immForm(OrCode, 5'd1, 5'd0, 13'd7), 5'd1, 32'd7);
        issue(immForm(OrCode, 5'd2, 5'd0, 13'd9), 5'd2, 32'd9);
        issue(regForm(SubccCode, 5'd3, 5'd1, 5'd2), 5'd3, 32'hFFFF_FFFE);   // N=1 C=1
        place(branchWord(1'b0, BrLess, 22'd4));                         // Taken to 28
        issue(immForm(OrCode, 5'd4, 5'd0, 13'd1), 5'd4, 32'd1);
        unreachable();
        unreachable();
        place(branchWord(1'b0, BrEq, 22'd3));                           // Z=0, falls through
        issue(immForm(OrCode, 5'd6, 5'd0, 13'd2), 5'd6, 32'd2);
        issue(immForm(OrCode, 5'd7, 5'd0, 13'd3), 5'd7, 32'd3);
        place(regForm(SubccCode, 5'd0, 5'd1, 5'd1));                    // Z=1, no retire
        place(branchWord(1'b0, BrEq, 22'd3));                           // Taken to 56
        issue(immForm(OrCode, 5'd9, 5'd0, 13'd4), 5'd9, 32'd4);
        unreachable();
        issue(regForm(AddccCode, 5'd11, 5'd1, 5'd2), 5'd11, 32'h10);
        place(branchWord(1'b0, BrNe, 22'd3));                           // Taken to 72
        issue(immForm(OrCode, 5'd12, 5'd0, 13'd5), 5'd12, 32'd5);
        unreachable();
        place(branchWord(1'b0, BrGreater, 22'd3));                      // Taken to 84
        issue(immForm(OrCode, 5'd13, 5'd0, 13'd6), 5'd13, 32'd6);
        unreachable();
        place(branchWord(1'b0, BrLess, 22'd3));                         // N^V=0, untaken
        issue(immForm(OrCode, 5'd14, 5'd0, 13'd7), 5'd14, 32'd7);
        issue(immForm(OrCode, 5'd15, 5'd0, 13'd8), 5'd15, 32'd8);
        runTest("branches");

        startProgram();
        issue(immForm(OrCode, 5'd1, 5'd0, 13'd1), 5'd1, 32'd1);
        place(regForm(SubccCode, 5'd0, 5'd1, 5'd1));                    // Z=1
        place(branchWord(1'b1, BrNe, 22'd3));                           // Untaken, slot squashed
        unreachable();
        issue(immForm(OrCode, 5'd3, 5'd0, 13'h11), 5'd3, 32'h11);
        place(branchWord(1'b1, BrAlways, 22'd3));                       // ba,a to 32
        unreachable();
        unreachable();
        place(immForm(OrCode, 5'd0, 5'd0, 13'h55));                     // Write to r0 is dropped
        issue(regForm(AddCode, 5'd6, 5'd0, 5'd1), 5'd6, 32'd1);
        issue(immForm(AddCode, 5'd7, 5'd0, 13'h22), 5'd7, 32'h22);
        place(branchWord(1'b1, BrEq, 22'd3));                           // Taken, slot kept
        issue(immForm(OrCode, 5'd8, 5'd0, 13'h33), 5'd8, 32'h33);
        unreachable();
        issue(immForm(OrCode, 5'd9, 5'd0, 13'h44), 5'd9, 32'h44);
        runTest("annul and r0");

        $display("tests %0d, failing %0d, check errors %0d, assertion failures %0d",
                 testCount, testFails, errors, uut.chk.assertFails);
        if (errors == 0 && uut.chk.assertFails == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- flist.f
sparcPkg.sv
fetchUnit.sv
instrDecoder.sv
branchCondition.sv
regFile.sv
forwardUnit.sv
executeStage.sv
sparcCore.sv
sparcCore_assertions.sv
sparcCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, pass is read from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module sparcCoreTb -f flist.f -o simv \
    && ./obj_dir/simv +verilator+error+limit+1000 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
